//--- logic/rv_pkg.sv
package rv_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS = 32;
  localparam int MEM_WORDS = 1024;
  localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // base opcodes of RV32I
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b00_000_11,
    OP_MISC_MEM = 7'b00_011_11,
    OP_IMM      = 7'b00_100_11,
    OP_AUIPC    = 7'b00_101_11,
    OP_STORE    = 7'b01_000_11,
    OP_REG      = 7'b01_100_11,
    OP_LUI      = 7'b01_101_11,
    OP_BRANCH   = 7'b11_000_11,
    OP_JALR     = 7'b11_001_11,
    OP_JAL      = 7'b11_011_11,
    OP_SYSTEM   = 7'b11_100_11
  } opcode_e;

  // branch conditions
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load and store widths
  localparam logic [2:0] F3_LB = 3'b000;
  localparam logic [2:0] F3_LH = 3'b001;
  localparam logic [2:0] F3_LW = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_SB = 3'b000;
  localparam logic [2:0] F3_SH = 3'b001;
  localparam logic [2:0] F3_SW = 3'b010;

  // integer ops, shared by register and immediate forms
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SR = 3'b101;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
  localparam logic [6:0] FUNCT7_ALT = 7'b010_0000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one fetched word, seen through each format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } insn_u;

  typedef enum logic [1:0] {
    WB_ALU, WB_LOAD, WB_LINK, WB_UPPER
  } wb_sel_e;

  typedef struct packed {
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    alu_op_e    alu_op;
    logic       src_b_imm;
    logic       src_a_pc;
    logic       reg_we;
    wb_sel_e    wb_sel;
    logic       is_branch;
    logic [2:0] funct3;
    logic       is_jal;
    logic       is_jalr;
    logic       is_load;
    logic       is_store;
    logic       is_ecall;
  } ctrl_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] byte_en;
  } dbus_t;

  typedef struct packed {
    logic                  we;
    logic [MEM_ADDR_W-1:0] addr;
    word_t                 data;
  } prog_t;

endpackage

//--- logic/rv_decoder.sv
module rv_decoder (
  input  rv_pkg::insn_u i_insn,
  output rv_pkg::ctrl_t o_ctrl,
  output rv_pkg::word_t o_imm
);

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = i_insn.r.funct3;
  assign funct7 = i_insn.r.funct7;

  // sign-extended immediate for each format
  assign imm_i = {{20{i_insn.i.imm[11]}}, i_insn.i.imm};
  assign imm_s = {{20{i_insn.s.imm_11_5[6]}}, i_insn.s.imm_11_5, i_insn.s.imm_4_0};
  assign imm_b = {{20{i_insn.b.imm_12}}, i_insn.b.imm_11, i_insn.b.imm_10_5,
                  i_insn.b.imm_4_1, 1'b0};
  assign imm_u = {i_insn.u.imm_31_12, 12'b0};
  assign imm_j = {{12{i_insn.j.imm_20}}, i_insn.j.imm_19_12, i_insn.j.imm_11,
                  i_insn.j.imm_10_1, 1'b0};

  // alt selects sub or arithmetic shift
  function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      rv_pkg::F3_ADD:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:  op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:  op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU: op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:  op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SR:   op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:   op = rv_pkg::ALU_OR;
      default:         op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    o_ctrl = '0;
    o_ctrl.rd = i_insn.r.rd;
    o_ctrl.rs1 = i_insn.r.rs1;
    o_ctrl.rs2 = i_insn.r.rs2;
    o_ctrl.funct3 = funct3;
    o_ctrl.alu_op = rv_pkg::ALU_ADD;
    o_ctrl.wb_sel = rv_pkg::WB_ALU;
    o_imm = '0;
    case (i_insn.r.opcode)
      rv_pkg::OP_LUI: begin
        o_imm = imm_u;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.wb_sel = rv_pkg::WB_UPPER;
      end
      rv_pkg::OP_AUIPC: begin
        o_imm = imm_u;
        o_ctrl.src_a_pc = 1'b1;
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.reg_we = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        o_imm = imm_j;
        o_ctrl.is_jal = 1'b1;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.wb_sel = rv_pkg::WB_LINK;
      end
      rv_pkg::OP_JALR: begin
        o_imm = imm_i;
        if (funct3 == 3'b000) begin
          o_ctrl.is_jalr = 1'b1;
          o_ctrl.src_b_imm = 1'b1;
          o_ctrl.reg_we = 1'b1;
          o_ctrl.wb_sel = rv_pkg::WB_LINK;
        end
      end
      rv_pkg::OP_BRANCH: begin
        o_imm = imm_b;
        // 010 and 011 are not branch codes
        o_ctrl.is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      rv_pkg::OP_LOAD: begin
        o_imm = imm_i;
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.wb_sel = rv_pkg::WB_LOAD;
        if (funct3 == rv_pkg::F3_LB || funct3 == rv_pkg::F3_LH || funct3 == rv_pkg::F3_LW ||
            funct3 == rv_pkg::F3_LBU || funct3 == rv_pkg::F3_LHU) begin
          o_ctrl.is_load = 1'b1;
          o_ctrl.reg_we = 1'b1;
        end
      end
      rv_pkg::OP_STORE: begin
        o_imm = imm_s;
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.is_store = (funct3 == rv_pkg::F3_SB) || (funct3 == rv_pkg::F3_SH) ||
                          (funct3 == rv_pkg::F3_SW);
      end
      rv_pkg::OP_IMM: begin
        o_imm = imm_i;
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.alu_op = alu_decode(funct3,
                                   (funct3 == rv_pkg::F3_SR) && (funct7 == rv_pkg::FUNCT7_ALT));
        // shift immediates carry funct7 in the upper bits
        if (funct3 == rv_pkg::F3_SLL) begin
          o_ctrl.reg_we = (funct7 == rv_pkg::FUNCT7_BASE);
        end else if (funct3 == rv_pkg::F3_SR) begin
          o_ctrl.reg_we = (funct7 == rv_pkg::FUNCT7_BASE) || (funct7 == rv_pkg::FUNCT7_ALT);
        end else begin
          o_ctrl.reg_we = 1'b1;
        end
      end
      rv_pkg::OP_REG: begin
        o_ctrl.alu_op = alu_decode(funct3, funct7 == rv_pkg::FUNCT7_ALT);
        o_ctrl.reg_we = (funct7 == rv_pkg::FUNCT7_BASE) ||
                        ((funct7 == rv_pkg::FUNCT7_ALT) &&
                         (funct3 == rv_pkg::F3_ADD || funct3 == rv_pkg::F3_SR));
      end
      rv_pkg::OP_SYSTEM: begin
        o_ctrl.is_ecall = (i_insn.i.imm == '0) && (i_insn.i.rs1 == '0) &&
                          (funct3 == 3'b000) && (i_insn.i.rd == '0);
      end
      default: begin
        // fence and unknown opcodes fall through as no-ops
      end
    endcase
  end

endmodule

//--- logic/rv_reg_file.sv
module rv_reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t i_rs1,
  input  rv_pkg::reg_addr_t i_rs2,
  output rv_pkg::word_t     o_rs1_data,
  output rv_pkg::word_t     o_rs2_data,
  input  logic              i_we,
  input  rv_pkg::reg_addr_t i_rd,
  input  rv_pkg::word_t     i_rd_data
);

  rv_pkg::word_t regs [rv_pkg::NUM_REGS];

  // x0 always reads zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

endmodule

//--- logic/rv_alu.sv
module rv_alu (
  input  rv_pkg::alu_op_e i_op,
  input  rv_pkg::word_t   i_a,
  input  rv_pkg::word_t   i_b,
  output rv_pkg::word_t   o_result
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD:  o_result = i_a + i_b;
      rv_pkg::ALU_SUB:  o_result = i_a - i_b;
      rv_pkg::ALU_SLL:  o_result = i_a << shamt;
      rv_pkg::ALU_SLT: begin
        o_result = ($signed(i_a) < $signed(i_b)) ? 32'd1 : 32'd0;
      end
      rv_pkg::ALU_SLTU: begin
        o_result = (i_a < i_b) ? 32'd1 : 32'd0;
      end
      rv_pkg::ALU_XOR:  o_result = i_a ^ i_b;
      rv_pkg::ALU_SRL:  o_result = i_a >> shamt;
      // arithmetic shift keeps the sign bit
      rv_pkg::ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
      rv_pkg::ALU_OR:   o_result = i_a | i_b;
      rv_pkg::ALU_AND:  o_result = i_a & i_b;
      default:          o_result = '0;
    endcase
  end

endmodule

//--- logic/rv_pc_unit.sv
module rv_pc_unit (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_run,
  input  rv_pkg::ctrl_t i_ctrl,
  input  rv_pkg::word_t i_imm,
  input  rv_pkg::word_t i_rs1_data,
  input  rv_pkg::word_t i_rs2_data,
  input  rv_pkg::word_t i_alu_result,
  output rv_pkg::word_t o_pc,
  output rv_pkg::word_t o_link,
  output logic          o_halt
);

  rv_pkg::word_t pc_q;
  rv_pkg::word_t pc_next;
  logic halt_q;
  logic taken;

  always_comb begin
    case (i_ctrl.funct3)
      rv_pkg::F3_BEQ:  taken = (i_rs1_data == i_rs2_data);
      rv_pkg::F3_BNE:  taken = (i_rs1_data != i_rs2_data);
      rv_pkg::F3_BLT:  taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
      rv_pkg::F3_BGE:  taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      rv_pkg::F3_BLTU: taken = (i_rs1_data < i_rs2_data);
      rv_pkg::F3_BGEU: taken = (i_rs1_data >= i_rs2_data);
      default:         taken = 1'b0;
    endcase
  end

  always_comb begin
    pc_next = o_link;
    if (i_ctrl.is_jal || (i_ctrl.is_branch && taken)) begin
      pc_next = pc_q + i_imm;
    end else if (i_ctrl.is_jalr) begin
      pc_next = {i_alu_result[31:1], 1'b0};
    end
  end

  // ecall leaves the pc on itself and halt sticks until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
      halt_q <= 1'b0;
    end else if (i_run && !halt_q) begin
      if (i_ctrl.is_ecall) begin
        halt_q <= 1'b1;
      end else begin
        pc_q <= pc_next;
      end
    end
  end

  assign o_pc = pc_q;
  assign o_link = pc_q + 32'd4;
  assign o_halt = halt_q;

endmodule

//--- logic/rv_lsu.sv
module rv_lsu (
  input  rv_pkg::ctrl_t i_ctrl,
  input  logic          i_halt,
  input  logic          i_run,
  input  rv_pkg::word_t i_addr,
  input  rv_pkg::word_t i_store_data,
  input  rv_pkg::word_t i_load_word,
  output rv_pkg::dbus_t o_dbus,
  output rv_pkg::word_t o_load_data
);

  logic [4:0] lane_shift;
  logic store_ok;
  rv_pkg::word_t load_shifted;

  // byte offset in bits
  assign lane_shift = {i_addr[1:0], 3'b000};
  assign store_ok = i_ctrl.is_store && i_run && !i_halt;
  assign load_shifted = i_load_word >> lane_shift;

  always_comb begin
    o_dbus.addr = i_addr;
    o_dbus.wdata = '0;
    o_dbus.byte_en = 4'b0000;
    case (i_ctrl.funct3)
      rv_pkg::F3_SB: begin
        o_dbus.wdata = {24'b0, i_store_data[7:0]} << lane_shift;
        o_dbus.byte_en = 4'b0001 << i_addr[1:0];
      end
      rv_pkg::F3_SH: begin
        o_dbus.wdata = {16'b0, i_store_data[15:0]} << lane_shift;
        o_dbus.byte_en = i_addr[1] ? 4'b1100 : 4'b0011;
      end
      rv_pkg::F3_SW: begin
        o_dbus.wdata = i_store_data;
        o_dbus.byte_en = 4'b1111;
      end
      default: begin
      end
    endcase
    // no lanes outside a live store
    if (!store_ok) begin
      o_dbus.byte_en = 4'b0000;
    end
  end

  always_comb begin
    o_load_data = '0;
    if (i_ctrl.is_load) begin
      case (i_ctrl.funct3)
        rv_pkg::F3_LB:  o_load_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
        rv_pkg::F3_LBU: o_load_data = {24'b0, load_shifted[7:0]};
        rv_pkg::F3_LH:  o_load_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
        rv_pkg::F3_LHU: o_load_data = {16'b0, load_shifted[15:0]};
        default:        o_load_data = i_load_word;
      endcase
    end
  end

endmodule

//--- logic/rv_memory.sv
module rv_memory (
  input  logic          clk,
  input  rv_pkg::word_t i_fetch_addr,
  output rv_pkg::word_t o_fetch_data,
  input  rv_pkg::dbus_t i_dbus,
  output rv_pkg::word_t o_load_word,
  input  rv_pkg::prog_t i_prog
);

  rv_pkg::word_t mem [rv_pkg::MEM_WORDS];

  logic [rv_pkg::MEM_ADDR_W-1:0] fetch_idx;
  logic [rv_pkg::MEM_ADDR_W-1:0] data_idx;

  // word index drops the byte offset
  assign fetch_idx = i_fetch_addr[rv_pkg::MEM_ADDR_W+1:2];
  assign data_idx = i_dbus.addr[rv_pkg::MEM_ADDR_W+1:2];

  // reads are asynchronous, so they see the pre-write value
  assign o_fetch_data = mem[fetch_idx];
  assign o_load_word = mem[data_idx];

  always_ff @(posedge clk) begin
    if (i_prog.we) begin
      mem[i_prog.addr] <= i_prog.data;
    end
    for (int b = 0; b < 4; b++) begin
      if (i_dbus.byte_en[b]) begin
        mem[data_idx][8*b +: 8] <= i_dbus.wdata[8*b +: 8];
      end
    end
  end

endmodule

//--- logic/rv_core_top.sv
module rv_core_top (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_run,
  input  rv_pkg::prog_t i_prog,
  output rv_pkg::dbus_t o_dbus,
  output rv_pkg::word_t o_pc,
  output logic          o_halt
);

  rv_pkg::word_t fetch_word;
  rv_pkg::insn_u insn;
  rv_pkg::ctrl_t ctrl;
  rv_pkg::word_t imm;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t alu_a;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t load_data;
  rv_pkg::word_t load_word;
  rv_pkg::word_t link;
  rv_pkg::word_t pc;
  rv_pkg::word_t rd_data;
  rv_pkg::dbus_t dbus;
  rv_pkg::prog_t prog;
  logic halt;
  logic reg_we;

  assign insn = fetch_word;

  // operand muxes
  assign alu_a = ctrl.src_a_pc ? pc : rs1_data;
  assign alu_b = ctrl.src_b_imm ? imm : rs2_data;

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::WB_LOAD:  rd_data = load_data;
      rv_pkg::WB_LINK:  rd_data = link;
      rv_pkg::WB_UPPER: rd_data = imm;
      default:          rd_data = alu_result;
    endcase
  end

  // nothing retires while stopped or halted
  assign reg_we = ctrl.reg_we && i_run && !halt;

  // program loads only land while the core is stopped
  always_comb begin
    prog = i_prog;
    prog.we = i_prog.we && !i_run;
  end

  rv_memory u_memory (
    .clk(clk), .i_fetch_addr(pc), .o_fetch_data(fetch_word),
    .i_dbus(dbus), .o_load_word(load_word), .i_prog(prog)
  );

  rv_decoder u_decoder (.i_insn(insn), .o_ctrl(ctrl), .o_imm(imm));

  rv_reg_file u_reg_file (
    .clk(clk), .rst(rst), .i_rs1(ctrl.rs1), .i_rs2(ctrl.rs2),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .i_we(reg_we), .i_rd(ctrl.rd), .i_rd_data(rd_data)
  );

  rv_alu u_alu (.i_op(ctrl.alu_op), .i_a(alu_a), .i_b(alu_b), .o_result(alu_result));

  rv_pc_unit u_pc_unit (
    .clk(clk), .rst(rst), .i_run(i_run), .i_ctrl(ctrl), .i_imm(imm),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_alu_result(alu_result),
    .o_pc(pc), .o_link(link), .o_halt(halt)
  );

  rv_lsu u_lsu (
    .i_ctrl(ctrl), .i_halt(halt), .i_run(i_run), .i_addr(alu_result),
    .i_store_data(rs2_data), .i_load_word(load_word),
    .o_dbus(dbus), .o_load_data(load_data)
  );

  assign o_dbus = dbus;
  assign o_pc = pc;
  assign o_halt = halt;

endmodule

//--- tests/rv_clock_gen.sv
module rv_clock_gen #(
  parameter int PERIOD_NS = 4,
  parameter int RST_CYCLES = 4
) (
  output logic o_clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

  // release on a falling edge away from the rising edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

//--- tests/rv_core_tb.sv
module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_TESTS = 6;
  localparam int TEST_CYCLES = 80;
  localparam int MARGIN_NS = 1000;
  localparam int HALT_LIMIT = 200;
  localparam rv_pkg::word_t DATA_BASE = 32'h0000_0800;

  logic clk;
  logic por_rst;
  logic test_rst;
  logic rst;
  logic run;
  rv_pkg::prog_t prog;
  rv_pkg::dbus_t dbus;
  rv_pkg::word_t pc;
  logic halt;

  integer seed = 32'h5b05_d558;
  int value_errs = 0;
  int other_errs = 0;
  rv_pkg::word_t prog_q[$];
  rv_pkg::dbus_t exp_q[$];

  assign rst = por_rst | test_rst;

  rv_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clock_gen (.o_clk(clk), .o_rst(por_rst));

  rv_core_top uut (
    .clk(clk), .rst(rst), .i_run(run), .i_prog(prog),
    .o_dbus(dbus), .o_pc(pc), .o_halt(halt)
  );

  // instruction encoders for each format
  function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
  endfunction

  function automatic rv_pkg::word_t i_type(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input rv_pkg::reg_addr_t rd, input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t s_type(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic rv_pkg::word_t b_type(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
  endfunction

  function automatic rv_pkg::word_t u_type(input logic [19:0] imm, input rv_pkg::reg_addr_t rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv_pkg::word_t j_type(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  function automatic rv_pkg::word_t ecall_word();
    return i_type('0, 0, 3'b000, 0, rv_pkg::OP_SYSTEM);
  endfunction

  function automatic void emit(input rv_pkg::word_t w);
    prog_q.push_back(w);
  endfunction

  function automatic rv_pkg::word_t next_pc();
    return prog_q.size() * 4;
  endfunction

  // lui rounds up when the low part is negative for addi
  function automatic void load_const(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t value);
    rv_pkg::word_t upper;
    upper = value + 32'h800;
    emit(u_type(upper[31:12], rd, rv_pkg::OP_LUI));
    emit(i_type(value, rd, rv_pkg::F3_ADD, rd, rv_pkg::OP_IMM));
  endfunction

  function automatic void expect_store(input rv_pkg::word_t addr, input rv_pkg::word_t data,
      input logic [3:0] be);
    rv_pkg::dbus_t d;
    d.addr = addr;
    d.wdata = data;
    d.byte_en = be;
    exp_q.push_back(d);
  endfunction

  function automatic logic signed_less(input rv_pkg::word_t a, input rv_pkg::word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  // reference results straight from the RV32I rules
  function automatic rv_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
      input rv_pkg::word_t a, input rv_pkg::word_t b);
    logic [4:0] sh;
    rv_pkg::word_t fill;
    sh = b[4:0];
    fill = a[31] ? ~(32'hffff_ffff >> sh) : '0;
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return {31'b0, signed_less(a, b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? ((a >> sh) | fill) : (a >> sh);
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input rv_pkg::word_t a,
      input rv_pkg::word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return signed_less(a, b);
      3'b101:  return !signed_less(a, b);
      3'b110:  return a < b;
      default: return !(a < b);
    endcase
  endfunction

  // wdata only matters in the enabled lanes
  task automatic check_store(input rv_pkg::dbus_t got, input rv_pkg::dbus_t exp);
    rv_pkg::word_t mask;
    mask = '0;
    for (int b = 0; b < 4; b++) begin
      if (exp.byte_en[b]) begin
        mask[8*b +: 8] = 8'hff;
      end
    end
    if (got.addr !== exp.addr) begin
      $display("Fail o_dbus.addr got %h expected %h at %0t", got.addr, exp.addr, $time);
      value_errs++;
    end
    if (got.byte_en !== exp.byte_en) begin
      $display("Fail o_dbus.byte_en got %h expected %h at %0t", got.byte_en, exp.byte_en, $time);
      value_errs++;
    end
    if ((got.wdata & mask) !== (exp.wdata & mask)) begin
      $display("Fail o_dbus.wdata got %h expected %h at %0t", got.wdata & mask,
               exp.wdata & mask, $time);
      value_errs++;
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail o_halt got %h expected %h at %0t", got, exp, $time);
      value_errs++;
    end
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t got, input rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
      value_errs++;
    end
  endtask

  // store monitor samples one ns before each rising edge
  always begin
    @(negedge clk);
    #(CLK_PERIOD / 4);
    if (dbus.byte_en !== 4'b0000) begin
      if (exp_q.size() == 0) begin
        $display("store to address %h with byte_en %h was not expected at %0t",
                 dbus.addr, dbus.byte_en, $time);
        other_errs++;
      end else begin
        check_store(dbus, exp_q.pop_front());
      end
    end
  end

  task automatic reset_core();
    @(negedge clk);
    run = 1'b0;
    prog = '0;
    test_rst = 1'b1;
    repeat (2) @(negedge clk);
    test_rst = 1'b0;
    prog_q.delete();
    exp_q.delete();
    check_halt(halt, 1'b0);
    check_word("o_pc", pc, '0);
  endtask

  task automatic load_program();
    logic [rv_pkg::MEM_ADDR_W-1:0] addr;
    addr = '0;
    foreach (prog_q[i]) begin
      @(negedge clk);
      prog.we = 1'b1;
      prog.addr = addr;
      prog.data = prog_q[i];
      addr++;
    end
    @(negedge clk);
    prog = '0;
  endtask

  // run stays high, so a halted core keeps being watched
  task automatic run_to_halt();
    int n;
    @(negedge clk);
    run = 1'b1;
    n = 0;
    while (!halt && n < HALT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!halt) begin
      $display("program did not reach ECALL within %0d cycles", HALT_LIMIT);
      other_errs++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected stores never appeared on the data bus", exp_q.size());
      other_errs++;
    end
  endtask

  task automatic power_on_state();
    while (por_rst !== 1'b0) begin
      @(negedge clk);
    end
    @(negedge clk);
    check_halt(halt, 1'b0);
    check_word("o_pc", pc, '0);
    check_word("o_dbus.byte_en", {28'b0, dbus.byte_en}, '0);
    // a store sitting at pc 0 must stay off the bus while stopped
    emit(s_type(0, 0, 0, rv_pkg::F3_SW));
    load_program();
    repeat (4) begin
      @(negedge clk);
      check_halt(halt, 1'b0);
      check_word("o_pc", pc, '0);
      check_word("o_dbus.byte_en", {28'b0, dbus.byte_en}, '0);
    end
  endtask

  task automatic alu_ops();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t r;
    rv_pkg::word_t field;
    rv_pkg::word_t off;
    logic [2:0] f3;
    logic [3:0] k;
    logic alt;
    reset_core();
    a = $random(seed);
    b = $random(seed);
    load_const(1, DATA_BASE);
    load_const(2, a);
    load_const(3, b);
    off = '0;
    // register forms with sub and sra last
    for (k = 0; k < 10; k++) begin
      f3 = (k == 9) ? 3'b101 : k[2:0];
      alt = k[3];
      emit(r_type(alt ? rv_pkg::FUNCT7_ALT : rv_pkg::FUNCT7_BASE, 3, 2, f3, 4));
      emit(s_type(off, 4, 1, rv_pkg::F3_SW));
      expect_store(DATA_BASE + off, alu_model(f3, alt, a, b), 4'b1111);
      off += 4;
    end
    // immediate forms with srai last
    for (k = 0; k < 9; k++) begin
      f3 = (k == 8) ? 3'b101 : k[2:0];
      alt = k[3];
      r = $random(seed);
      if (f3 == rv_pkg::F3_SLL || f3 == rv_pkg::F3_SR) begin
        field = {20'b0, alt ? rv_pkg::FUNCT7_ALT : rv_pkg::FUNCT7_BASE, r[4:0]};
      end else begin
        field = {20'b0, r[11:0]};
      end
      emit(i_type(field, 2, f3, 4, rv_pkg::OP_IMM));
      emit(s_type(off, 4, 1, rv_pkg::F3_SW));
      expect_store(DATA_BASE + off, alu_model(f3, alt, a, {{20{field[11]}}, field[11:0]}),
                   4'b1111);
      off += 4;
    end
    emit(ecall_word());
    load_program();
    run_to_halt();
  endtask

  task automatic upper_and_jumps();
    rv_pkg::word_t p;
    rv_pkg::word_t target;
    reset_core();
    load_const(1, DATA_BASE);
    emit(u_type(20'h12345, 5, rv_pkg::OP_LUI));
    p = next_pc();
    emit(u_type(20'h00010, 6, rv_pkg::OP_AUIPC));
    emit(s_type(0, 5, 1, rv_pkg::F3_SW));
    emit(s_type(4, 6, 1, rv_pkg::F3_SW));
    expect_store(DATA_BASE, 32'h1234_5000, 4'b1111);
    expect_store(DATA_BASE + 4, p + 32'h0001_0000, 4'b1111);
    // jal over two stores
    p = next_pc();
    emit(j_type(12, 7));
    emit(s_type(32, 5, 1, rv_pkg::F3_SW));
    emit(s_type(36, 5, 1, rv_pkg::F3_SW));
    emit(s_type(8, 7, 1, rv_pkg::F3_SW));
    expect_store(DATA_BASE + 8, p + 4, 4'b1111);
    // jalr from an odd sum drops target bit 0
    target = next_pc() + 20;
    load_const(8, target - 3);
    p = next_pc();
    emit(i_type(4, 8, 3'b000, 9, rv_pkg::OP_JALR));
    emit(s_type(40, 5, 1, rv_pkg::F3_SW));
    emit(s_type(44, 5, 1, rv_pkg::F3_SW));
    emit(s_type(12, 9, 1, rv_pkg::F3_SW));
    expect_store(DATA_BASE + 12, p + 4, 4'b1111);
    emit(ecall_word());
    load_program();
    run_to_halt();
  endtask

  task automatic branch_conditions();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t x;
    rv_pkg::word_t y;
    rv_pkg::word_t marker;
    rv_pkg::reg_addr_t r1;
    rv_pkg::reg_addr_t r2;
    logic [2:0] idx;
    logic [2:0] f3;
    logic [3:0] n;
    reset_core();
    a = $random(seed) | 32'h8000_0000;
    b = $random(seed) & 32'h7fff_ffff;
    load_const(1, DATA_BASE);
    load_const(2, a);
    load_const(3, b);
    for (n = 0; n < 12; n++) begin
      idx = n[3:1];
      f3 = (idx < 3'd2) ? idx : idx + 3'd2;
      r1 = 2;
      r2 = 3;
      // second case flips the operands or makes them equal for beq and bne
      if (n[0]) begin
        r1 = f3[2] ? 3 : 2;
        r2 = 2;
      end
      x = (r1 == 2) ? a : b;
      y = (r2 == 2) ? a : b;
      marker = 32'h100 + 2 * n;
      emit(b_type(12, r2, r1, f3));
      emit(i_type(marker, 0, rv_pkg::F3_ADD, 10, rv_pkg::OP_IMM));
      emit(j_type(8, 0));
      emit(i_type(marker + 1, 0, rv_pkg::F3_ADD, 10, rv_pkg::OP_IMM));
      emit(s_type(4 * n, 10, 1, rv_pkg::F3_SW));
      expect_store(DATA_BASE + 4 * n, branch_model(f3, x, y) ? marker + 1 : marker, 4'b1111);
    end
    emit(ecall_word());
    load_program();
    run_to_halt();
  endtask

  task automatic byte_half_access();
    rv_pkg::word_t w;
    rv_pkg::word_t offset;
    rv_pkg::word_t ext;
    logic [7:0] bval;
    logic [15:0] hval;
    logic [2:0] f3;
    logic [3:0] n;
    reset_core();
    // byte 0 and the upper half negative while byte 1 and the lower half stay positive
    w = ($random(seed) & 32'h7f7f_7f7f) | 32'h8000_0080;
    load_const(1, DATA_BASE);
    load_const(2, w);
    emit(s_type(0, 2, 1, rv_pkg::F3_SW));
    expect_store(DATA_BASE, w, 4'b1111);
    // the stored byte or half must sit in whichever lane is enabled
    for (n = 0; n < 4; n++) begin
      emit(s_type(4 + n, 2, 1, rv_pkg::F3_SB));
      expect_store(DATA_BASE + 4 + n, {4{w[7:0]}}, 4'b0001 << n);
    end
    for (n = 0; n < 2; n++) begin
      emit(s_type(8 + 2 * n, 2, 1, rv_pkg::F3_SH));
      expect_store(DATA_BASE + 8 + 2 * n, {2{w[15:0]}}, 4'b0011 << (2 * n));
    end
    for (n = 0; n < 12; n++) begin
      if (n < 8) begin
        f3 = (n < 4) ? rv_pkg::F3_LB : rv_pkg::F3_LBU;
        offset = {30'b0, n[1:0]};
        bval = w[8 * offset +: 8];
        ext = {24'b0, bval};
        // a set top bit weighs minus 256 when signed
        if (f3 == rv_pkg::F3_LB && bval[7]) begin
          ext = ext - 32'h100;
        end
      end else begin
        f3 = (n < 10) ? rv_pkg::F3_LH : rv_pkg::F3_LHU;
        offset = {30'b0, n[0], 1'b0};
        hval = w[8 * offset +: 16];
        ext = {16'b0, hval};
        if (f3 == rv_pkg::F3_LH && hval[15]) begin
          ext = ext - 32'h1_0000;
        end
      end
      emit(i_type(offset, 1, f3, 4, rv_pkg::OP_LOAD));
      emit(s_type(16 + 4 * n, 4, 1, rv_pkg::F3_SW));
      expect_store(DATA_BASE + 16 + 4 * n, ext, 4'b1111);
    end
    emit(ecall_word());
    load_program();
    run_to_halt();
  endtask

  task automatic halt_freeze();
    rv_pkg::word_t halt_pc;
    reset_core();
    load_const(1, DATA_BASE);
    emit(i_type(32'h55, 0, rv_pkg::F3_ADD, 2, rv_pkg::OP_IMM));
    emit(s_type(0, 2, 1, rv_pkg::F3_SW));
    expect_store(DATA_BASE, 32'h55, 4'b1111);
    halt_pc = next_pc();
    emit(ecall_word());
    // must never reach the bus
    emit(s_type(4, 2, 1, rv_pkg::F3_SW));
    emit(ecall_word());
    load_program();
    run_to_halt();
    check_halt(halt, 1'b1);
    check_word("o_pc", pc, halt_pc);
    repeat (8) @(negedge clk);
    check_halt(halt, 1'b1);
    check_word("o_pc", pc, halt_pc);
  endtask

  initial begin
    run = 1'b0;
    prog = '0;
    test_rst = 1'b0;
    power_on_state();
    alu_ops();
    upper_and_jumps();
    branch_conditions();
    byte_half_access();
    halt_freeze();
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog sized from the test budget
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
    $display("watchdog expired at %0t, the tests did not finish", $time);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- filelist.f
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_reg_file.sv
logic/rv_alu.sv
logic/rv_pc_unit.sv
logic/rv_lsu.sv
logic/rv_memory.sv
logic/rv_core_top.sv
tests/rv_clock_gen.sv
tests/rv_core_tb.sv
